// ==== hdl/axi_uart_defs.svh ====
// Widths, FIFO depth, register offsets and bit positions of the AXI-Lite UART.
// Included by the package and by every RTL file.
`ifndef AXI_UART_DEFS_SVH
`define AXI_UART_DEFS_SVH

`define AXI_UART_ADDR_W   5     // byte address
`define AXI_UART_DATA_W   32
`define AXI_UART_LSB_W    2     // byte offset inside a word
`define UART_DATA_W       8
`define UART_DIV_W        16
`define UART_FIFO_DEPTH   8
`define UART_DIV_INIT     434   // clocks per bit after reset

`define UART_REG_RBR_THR  0     // word offsets
`define UART_REG_IER      1
`define UART_REG_LCR      3
`define UART_REG_LSR      5
`define UART_REG_DIV      7

`define UART_LCR_STOP     0     // 0 one stop bit, 1 two
`define UART_LCR_PEN      1
`define UART_LCR_PMODE    2     // 0 even, 1 odd
`define UART_LCR_DLAB     7

`define UART_LSR_DR       0
`define UART_LSR_THRE     5
`define UART_LSR_TEMT     6

`endif

// ==== hdl/axi_uart_pkg.sv ====
// Types shared by the UART blocks: AXI-Lite channel bundles, line configuration
// and the field views of a register word.
`include "axi_uart_defs.svh"

package axi_uart_pkg;

  typedef struct packed {
    logic [`AXI_UART_ADDR_W-1:0] awaddr;
    logic                        awvalid;
    logic [`AXI_UART_DATA_W-1:0] wdata;
    logic                        wvalid;
    logic                        bready;
  } axi_wr_req_t;

  typedef struct packed {
    logic awready;
    logic wready;
    logic bvalid;
  } axi_wr_rsp_t;

  typedef struct packed {
    logic [`AXI_UART_ADDR_W-1:0] araddr;
    logic                        arvalid;
    logic                        rready;
  } axi_rd_req_t;

  typedef struct packed {
    logic                        arready;
    logic [`AXI_UART_DATA_W-1:0] rdata;
    logic                        rvalid;
  } axi_rd_rsp_t;

  typedef struct packed {
    logic                   stop_bits;
    logic                   parity_en;
    logic                   parity_mode;
    logic [`UART_DIV_W-1:0] divisor;
  } uart_cfg_t;

  typedef struct packed {
    logic [`AXI_UART_DATA_W-`UART_LCR_DLAB-2:0]      rsvd_hi;
    logic                                            dlab;
    logic [`UART_LCR_DLAB-`UART_LCR_PMODE-2:0]       rsvd_lo;
    logic                                            parity_mode;
    logic [`UART_LCR_PMODE-`UART_LCR_PEN-1:0]        parity_en;
    logic [`UART_LCR_PEN-`UART_LCR_STOP-1:0]         stop_bits;
  } lcr_t;

  typedef struct packed {
    logic [`AXI_UART_DATA_W-`UART_LSR_TEMT-2:0]      rsvd_hi;
    logic                                            temt;
    logic                                            thre;
    logic [`UART_LSR_THRE-`UART_LSR_DR-2:0]          rsvd_lo;
    logic                                            data_ready;
  } lsr_t;

  // one bus word seen raw or through a register layout
  typedef union packed {
    logic [`AXI_UART_DATA_W-1:0] raw;
    lcr_t                        lcr;
    lsr_t                        lsr;
  } axi_word_u;

endpackage

// ==== hdl/uart_fifo.sv ====
`timescale 1ns/1ps
// Synchronous circular-buffer FIFO for UART characters, one instance per
// direction. Head entry is visible on data_o while not empty.
`include "axi_uart_defs.svh"

module uart_fifo #(
  parameter int DEPTH = `UART_FIFO_DEPTH
) (
  input  logic                    fixed_clk_i,
  input  logic                    axi_aresetn_i,
  input  logic                    push_i,
  input  logic [`UART_DATA_W-1:0] data_i,
  input  logic                    pop_i,
  output logic [`UART_DATA_W-1:0] data_o,
  output logic                    empty_o,
  output logic                    full_o
);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [`UART_DATA_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]        wr_ptr, rd_ptr;
  logic [PTR_W:0]          count;
  logic                    do_push, do_pop;

  assign do_push = push_i && !full_o;  // push into a full FIFO is lost
  assign do_pop  = pop_i && !empty_o;
  assign empty_o = (count == '0);
  assign full_o  = (count == (PTR_W+1)'(DEPTH));
  assign data_o  = mem[rd_ptr];

  always_ff @(posedge fixed_clk_i) begin
    if (do_push) mem[wr_ptr] <= data_i;
  end

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;  // both or neither leaves occupancy
      endcase
    end
  end

endmodule

// ==== hdl/uart_tx.sv ====
`timescale 1ns/1ps
// UART serializer. Pops a byte from the tx FIFO when idle and sends start,
// eight data bits LSB first, optional parity and one or two stop bits.
`include "axi_uart_defs.svh"

module uart_tx (
  input  logic                    fixed_clk_i,
  input  logic                    axi_aresetn_i,
  input  axi_uart_pkg::uart_cfg_t cfg_i,
  input  logic [`UART_DATA_W-1:0] data_i,
  input  logic                    empty_i,
  output logic                    pop_o,
  output logic                    busy_o,
  output logic                    uart_tx_o
);
  typedef enum logic [2:0] {TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP} tx_state_e;

  tx_state_e               state_q;
  logic [`UART_DIV_W-1:0]  baud_cnt;
  logic [2:0]              bit_cnt;
  logic [`UART_DATA_W-1:0] shift_q;
  logic                    parity_q;
  logic                    bit_done;

  assign bit_done = (baud_cnt == cfg_i.divisor - 1'b1);
  assign pop_o    = (state_q == TX_IDLE) && !empty_i;
  assign busy_o   = (state_q != TX_IDLE);

  always_ff @(posedge fixed_clk_i) begin
    if (pop_o) begin
      shift_q  <= data_i;
      parity_q <= ^data_i ^ cfg_i.parity_mode;  // odd mode inverts
    end else if (bit_done && (state_q == TX_START || state_q == TX_DATA)) begin
      shift_q <= shift_q >> 1;
    end
  end

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      state_q   <= TX_IDLE;
      baud_cnt  <= '0;
      bit_cnt   <= '0;
      uart_tx_o <= 1'b1;  // line idles high
    end else begin
      baud_cnt <= (state_q == TX_IDLE || bit_done) ? '0 : baud_cnt + 1'b1;
      case (state_q)
        TX_IDLE: if (pop_o) begin
          uart_tx_o <= 1'b0;
          state_q   <= TX_START;
        end
        TX_START: if (bit_done) begin
          uart_tx_o <= shift_q[0];
          bit_cnt   <= '0;
          state_q   <= TX_DATA;
        end
        TX_DATA: if (bit_done) begin
          bit_cnt <= bit_cnt + 1'b1;  // wraps to 0 for the stop count
          if (bit_cnt != 3'd7) begin
            uart_tx_o <= shift_q[0];
          end else if (cfg_i.parity_en) begin
            uart_tx_o <= parity_q;
            state_q   <= TX_PARITY;
          end else begin
            uart_tx_o <= 1'b1;
            state_q   <= TX_STOP;
          end
        end
        TX_PARITY: if (bit_done) begin
          uart_tx_o <= 1'b1;
          state_q   <= TX_STOP;
        end
        TX_STOP: if (bit_done) begin
          if (bit_cnt == {2'b00, cfg_i.stop_bits}) state_q <= TX_IDLE;
          else bit_cnt <= bit_cnt + 1'b1;
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

endmodule

// ==== hdl/uart_rx.sv ====
`timescale 1ns/1ps
// UART deserializer. Synchronizes the line, samples each bit at its middle and
// pushes the byte only when parity and the first stop bit are good.
`include "axi_uart_defs.svh"

module uart_rx (
  input  logic                    fixed_clk_i,
  input  logic                    axi_aresetn_i,
  input  axi_uart_pkg::uart_cfg_t cfg_i,
  input  logic                    uart_rx_i,
  output logic                    push_o,
  output logic [`UART_DATA_W-1:0] data_o
);
  typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP} rx_state_e;

  rx_state_e              state_q;
  logic                   rx_meta, rx_s;
  logic [`UART_DIV_W-1:0] baud_cnt;
  logic [2:0]             bit_cnt;
  logic                   par_err;
  logic                   sample;

  // half a bit into the start bit, then one full bit per sample
  assign sample = (state_q == RX_START) ? (baud_cnt == (cfg_i.divisor >> 1))
                                        : (baud_cnt == cfg_i.divisor - 1'b1);

  always_ff @(posedge fixed_clk_i) begin
    if (state_q == RX_DATA && sample) data_o <= {rx_s, data_o[`UART_DATA_W-1:1]};
  end

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      rx_meta  <= 1'b1;
      rx_s     <= 1'b1;
      state_q  <= RX_IDLE;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      par_err  <= 1'b0;
      push_o   <= 1'b0;
    end else begin
      rx_meta  <= uart_rx_i;  // two-flop synchronizer
      rx_s     <= rx_meta;
      push_o   <= 1'b0;
      baud_cnt <= (state_q == RX_IDLE || sample) ? '0 : baud_cnt + 1'b1;
      case (state_q)
        RX_IDLE: if (!rx_s) begin
          par_err <= 1'b0;
          state_q <= RX_START;
        end
        RX_START: if (sample) begin
          bit_cnt <= '0;
          state_q <= rx_s ? RX_IDLE : RX_DATA;  // glitch, not a start bit
        end
        RX_DATA: if (sample) begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == 3'd7) state_q <= cfg_i.parity_en ? RX_PARITY : RX_STOP;
        end
        RX_PARITY: if (sample) begin
          par_err <= rx_s ^ (^data_o) ^ cfg_i.parity_mode;
          state_q <= RX_STOP;
        end
        RX_STOP: if (sample) begin
          push_o  <= rx_s && !par_err;  // bad frames are dropped
          state_q <= RX_IDLE;
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

endmodule

// ==== hdl/uart_axi_slave.sv ====
`timescale 1ns/1ps
// AXI4-Lite register slave of the UART. Separate read and write handshake FSMs,
// the LCR, IER and divisor registers, LSR status and the receive interrupt.
`include "axi_uart_defs.svh"

module uart_axi_slave (
  input  logic                      fixed_clk_i,
  input  logic                      axi_aresetn_i,
  input  axi_uart_pkg::axi_wr_req_t wr_req_i,
  output axi_uart_pkg::axi_wr_rsp_t wr_rsp_o,
  input  axi_uart_pkg::axi_rd_req_t rd_req_i,
  output axi_uart_pkg::axi_rd_rsp_t rd_rsp_o,
  input  logic [`UART_DATA_W-1:0]   rx_data_i,
  input  logic                      rx_empty_i,
  output logic                      rx_pop_o,
  input  logic                      tx_full_i,
  input  logic                      tx_empty_i,
  input  logic                      tx_busy_i,
  output logic                      tx_push_o,
  output logic [`UART_DATA_W-1:0]   tx_data_o,
  output axi_uart_pkg::uart_cfg_t   cfg_o,
  output logic                      read_interrupt_o
);
  import axi_uart_pkg::*;

  typedef enum logic {IDLE, ACK} bus_state_e;

  bus_state_e                                  wr_state, rd_state;
  logic [`AXI_UART_ADDR_W-`AXI_UART_LSB_W-1:0] wr_off, rd_off;
  axi_word_u                                   wr_word, rd_word;
  lcr_t                                        lcr_q;
  logic                                        ier_q;
  logic [`UART_DIV_W-1:0]                      div_q;
  logic                                        awready_q, wready_q, bvalid_q;
  logic                                        arready_q, rvalid_q;
  logic [`AXI_UART_DATA_W-1:0]                 rdata_q;
  logic                                        thr_stall, wr_start, rd_start;
  logic                                        rbr_hit;

  assign wr_off      = wr_req_i.awaddr[`AXI_UART_ADDR_W-1:`AXI_UART_LSB_W];
  assign rd_off      = rd_req_i.araddr[`AXI_UART_ADDR_W-1:`AXI_UART_LSB_W];
  assign wr_word.raw = wr_req_i.wdata;

  // THR write waits in idle until the tx FIFO has room
  assign thr_stall = (wr_off == `UART_REG_RBR_THR) && !lcr_q.dlab && tx_full_i;
  assign wr_start  = (wr_state == IDLE) && wr_req_i.awvalid && wr_req_i.wvalid && !thr_stall;
  assign rd_start  = (rd_state == IDLE) && rd_req_i.arvalid;
  assign rbr_hit   = (rd_off == `UART_REG_RBR_THR) && !lcr_q.dlab && !rx_empty_i;

  assign wr_rsp_o = '{awready: awready_q, wready: wready_q, bvalid: bvalid_q};
  assign rd_rsp_o = '{arready: arready_q, rdata: rdata_q, rvalid: rvalid_q};
  assign cfg_o    = '{stop_bits:   lcr_q.stop_bits,
                      parity_en:   lcr_q.parity_en,
                      parity_mode: lcr_q.parity_mode,
                      divisor:     div_q};

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      wr_state  <= IDLE;
      awready_q <= 1'b0;
      wready_q  <= 1'b0;
      bvalid_q  <= 1'b0;
      tx_push_o <= 1'b0;
      lcr_q     <= '0;
      ier_q     <= 1'b0;
      div_q     <= `UART_DIV_W'(`UART_DIV_INIT);
    end else begin
      awready_q <= 1'b0;  // ready lasts a single cycle
      wready_q  <= 1'b0;
      tx_push_o <= 1'b0;
      case (wr_state)
        IDLE: if (wr_start) begin
          awready_q <= 1'b1;
          wready_q  <= 1'b1;
          bvalid_q  <= 1'b1;
          wr_state  <= ACK;
          case (wr_off)
            `UART_REG_RBR_THR: tx_push_o <= !lcr_q.dlab;  // dropped under DLAB
            `UART_REG_IER:     if (!lcr_q.dlab) ier_q <= wr_word.raw[0];
            `UART_REG_LCR:     lcr_q <= wr_word.lcr;
            `UART_REG_DIV:     if (lcr_q.dlab) div_q <= wr_word.raw[`UART_DIV_W-1:0];
            default: ;         // unmapped, complete with no effect
          endcase
        end
        ACK: if (wr_req_i.bready) begin
          bvalid_q <= 1'b0;
          wr_state <= IDLE;
        end
        default: wr_state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge fixed_clk_i) begin
    if (wr_start) tx_data_o <= wr_word.raw[`UART_DATA_W-1:0];
  end

  // read word mux, LSR assembled through its field view
  always_comb begin
    rd_word = '0;
    case (rd_off)
      `UART_REG_RBR_THR: if (rbr_hit) rd_word.raw[`UART_DATA_W-1:0] = rx_data_i;
      `UART_REG_IER:     rd_word.raw[0] = ier_q;
      `UART_REG_LCR:     rd_word.lcr = lcr_q;
      `UART_REG_LSR: begin
        rd_word.lsr.data_ready = !rx_empty_i;
        rd_word.lsr.thre       = !tx_full_i;
        rd_word.lsr.temt       = tx_empty_i && !tx_busy_i;
      end
      `UART_REG_DIV:     rd_word.raw[`UART_DIV_W-1:0] = div_q;
      default: ;
    endcase
  end

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      rd_state  <= IDLE;
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
      rx_pop_o  <= 1'b0;
    end else begin
      arready_q <= 1'b0;
      rx_pop_o  <= 1'b0;
      case (rd_state)
        IDLE: if (rd_start) begin
          arready_q <= 1'b1;
          rvalid_q  <= 1'b1;
          rx_pop_o  <= rbr_hit;  // pop lands with arready
          rd_state  <= ACK;
        end
        ACK: if (rd_req_i.rready) begin
          rvalid_q <= 1'b0;
          rd_state <= IDLE;
        end
        default: rd_state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge fixed_clk_i) begin
    if (rd_start) rdata_q <= rd_word.raw;  // held through the ack state
  end

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      read_interrupt_o <= 1'b0;
    end else begin
      read_interrupt_o <= !rx_empty_i && ier_q;
    end
  end

endmodule

// ==== hdl/axi_uart_top.sv ====
`timescale 1ns/1ps
// AXI4-Lite UART top level. Connects the register slave, both FIFOs and the
// serial transmitter and receiver; everything runs on fixed_clk_i.
`include "axi_uart_defs.svh"

module axi_uart_top (
  input  logic                      fixed_clk_i,
  input  logic                      axi_aresetn_i,
  input  axi_uart_pkg::axi_wr_req_t axi_wr_req_i,
  output axi_uart_pkg::axi_wr_rsp_t axi_wr_rsp_o,
  input  axi_uart_pkg::axi_rd_req_t axi_rd_req_i,
  output axi_uart_pkg::axi_rd_rsp_t axi_rd_rsp_o,
  input  logic                      uart_rx_i,
  output logic                      uart_tx_o,
  output logic                      read_interrupt_o
);
  import axi_uart_pkg::*;

  uart_cfg_t              cfg;
  logic                   rx_push, rx_pop, rx_empty;
  logic [`UART_DATA_W-1:0] rx_byte, rx_head;
  logic                   tx_push, tx_pop, tx_empty, tx_full, tx_busy;
  logic [`UART_DATA_W-1:0] tx_byte, tx_head;

  uart_axi_slave uart_axi_slave_inst (
    .fixed_clk_i (fixed_clk_i), .axi_aresetn_i (axi_aresetn_i),
    .wr_req_i    (axi_wr_req_i), .wr_rsp_o (axi_wr_rsp_o),
    .rd_req_i    (axi_rd_req_i), .rd_rsp_o (axi_rd_rsp_o),
    .rx_data_i   (rx_head), .rx_empty_i (rx_empty), .rx_pop_o (rx_pop),
    .tx_full_i   (tx_full), .tx_empty_i (tx_empty), .tx_busy_i (tx_busy),
    .tx_push_o   (tx_push), .tx_data_o (tx_byte),
    .cfg_o       (cfg), .read_interrupt_o (read_interrupt_o)
  );

  uart_fifo #(.DEPTH(`UART_FIFO_DEPTH)) rx_fifo (
    .fixed_clk_i (fixed_clk_i), .axi_aresetn_i (axi_aresetn_i),
    .push_i      (rx_push), .data_i (rx_byte), .pop_i (rx_pop),
    .data_o      (rx_head), .empty_o (rx_empty), .full_o ()
  );

  uart_fifo #(.DEPTH(`UART_FIFO_DEPTH)) tx_fifo (
    .fixed_clk_i (fixed_clk_i), .axi_aresetn_i (axi_aresetn_i),
    .push_i      (tx_push), .data_i (tx_byte), .pop_i (tx_pop),
    .data_o      (tx_head), .empty_o (tx_empty), .full_o (tx_full)
  );

  uart_tx uart_tx_inst (
    .fixed_clk_i (fixed_clk_i), .axi_aresetn_i (axi_aresetn_i), .cfg_i (cfg),
    .data_i      (tx_head), .empty_i (tx_empty),
    .pop_o       (tx_pop), .busy_o (tx_busy), .uart_tx_o (uart_tx_o)
  );

  uart_rx uart_rx_inst (
    .fixed_clk_i (fixed_clk_i), .axi_aresetn_i (axi_aresetn_i), .cfg_i (cfg),
    .uart_rx_i   (uart_rx_i), .push_o (rx_push), .data_o (rx_byte)
  );

endmodule

// ==== verif/axi_uart_asserts.sv ====
`timescale 1ns/1ps
// AXI-Lite handshake checks on the UART ports, bound into axi_uart_top.
module axi_uart_asserts (
  input logic                      fixed_clk_i,
  input logic                      axi_aresetn_i,
  input axi_uart_pkg::axi_wr_req_t wr_req_i,
  input axi_uart_pkg::axi_wr_rsp_t wr_rsp_i,
  input axi_uart_pkg::axi_rd_req_t rd_req_i,
  input axi_uart_pkg::axi_rd_rsp_t rd_rsp_i
);
  bvalid_held: assert property (@(posedge fixed_clk_i) disable iff (!axi_aresetn_i)
      wr_rsp_i.bvalid && !wr_req_i.bready |=> wr_rsp_i.bvalid)
    else $error("bvalid fell before bready");

  rvalid_held: assert property (@(posedge fixed_clk_i) disable iff (!axi_aresetn_i)
      rd_rsp_i.rvalid && !rd_req_i.rready |=> rd_rsp_i.rvalid && $stable(rd_rsp_i.rdata))
    else $error("rvalid or rdata changed before rready");

  ready_pair: assert property (@(posedge fixed_clk_i) disable iff (!axi_aresetn_i)
      wr_rsp_i.awready == wr_rsp_i.wready)
    else $error("awready and wready differ");
endmodule

bind axi_uart_top axi_uart_asserts axi_uart_asserts_inst (
  .fixed_clk_i (fixed_clk_i), .axi_aresetn_i (axi_aresetn_i),
  .wr_req_i    (axi_wr_req_i), .wr_rsp_i (axi_wr_rsp_o),
  .rd_req_i    (axi_rd_req_i), .rd_rsp_i (axi_rd_rsp_o)
);

// ==== verif/axi_uart_tb.sv ====
`timescale 1ns/1ps
// Testbench of the AXI-Lite UART. Runs the operations of the testdata file on
// the DUT, drives frames onto the rx line and decodes frames from the tx line.
`include "axi_uart_defs.svh"

module axi_uart_tb;
  import axi_uart_pkg::*;

  localparam int TMO = 2000;  // cycles allowed per wait

  logic        fixed_clk, axi_aresetn, uart_rx, uart_tx, read_interrupt;
  axi_wr_req_t wr_req;
  axi_wr_rsp_t wr_rsp;
  axi_rd_req_t rd_req;
  axi_rd_rsp_t rd_rsp;
  logic [31:0] seed = 32'h49ac;
  logic [7:0]  lcr_sh;       // line config as last written
  logic [15:0] div_sh;
  logic [7:0]  tx_seen [$];  // bytes decoded from uart_tx_o
  int          errors, test_err, tests;
  int          mon_left, mon_timer, mon_n;
  logic [11:0] mon_frame, frame;

  axi_uart_top axi_uart_top_inst (
    .fixed_clk_i  (fixed_clk), .axi_aresetn_i (axi_aresetn),
    .axi_wr_req_i (wr_req), .axi_wr_rsp_o (wr_rsp),
    .axi_rd_req_i (rd_req), .axi_rd_rsp_o (rd_rsp),
    .uart_rx_i    (uart_rx), .uart_tx_o (uart_tx), .read_interrupt_o (read_interrupt)
  );

  initial begin
    fixed_clk = 1'b0;
    forever #50 fixed_clk = ~fixed_clk;
  end

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  function automatic void report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    $display("error at %0d ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    test_err++;
  endfunction

  function automatic void report_failure(string what);
    $display("failure at %0d ns: %s", $time, what);
    test_err++;
  endfunction

  function automatic void finish_test(int num);
    if (test_err == 0) $display("test %0d passed", num);
    else $display("test %0d failed with %0d errors", num, test_err);
    errors += test_err;
    test_err = 0;
    tests++;
  endfunction

  // tx line decoder, samples each bit at its middle
  always @(posedge fixed_clk) begin
    if (mon_left == 0) begin
      if (axi_aresetn && !uart_tx) begin
        mon_n     = 10 + lcr_sh[1] + lcr_sh[0];
        mon_left  = mon_n + 1;  // last step is the tail of the stop bit
        mon_timer = div_sh / 2 - 1;
      end
    end else if (mon_timer != 0) begin
      mon_timer = mon_timer - 1;
    end else begin
      mon_left = mon_left - 1;
      if (mon_left == 0) begin
        frame = mon_frame >> (12 - mon_n);
        if (frame[0] || !frame[9 + lcr_sh[1]] || (lcr_sh[0] && !frame[10 + lcr_sh[1]]) ||
            (lcr_sh[1] && frame[9] != (^frame[8:1] ^ lcr_sh[2])))
          report_failure("bad start, parity or stop bit on uart_tx_o");
        tx_seen.push_back(frame[8:1]);
      end else begin
        mon_frame = {uart_tx, mon_frame[11:1]};
        mon_timer = (mon_left == 1) ? div_sh / 2 - 1 : div_sh - 1;
      end
    end
  end

  task automatic bus_write(input logic [4:0] addr, input logic [31:0] data);
    int t;
    int delay;
    @(posedge fixed_clk);
    wr_req.awaddr  <= addr;
    wr_req.wdata   <= data;
    wr_req.awvalid <= 1'b1;
    wr_req.wvalid  <= 1'b1;
    t = 0;
    do begin
      @(posedge fixed_clk);
      t++;
    end while (!wr_rsp.awready && t < TMO);
    if (!wr_rsp.awready) begin
      report_failure("write address never accepted");
    end else if (wr_rsp.wready !== 1'b1) begin
      report_mismatch("wready", 32'(wr_rsp.wready), 32'd1);  // rises with awready
    end
    wr_req.awvalid <= 1'b0;
    wr_req.wvalid  <= 1'b0;
    delay = int'(lcg_next() >> 16) % 4;
    repeat (delay) @(posedge fixed_clk);
    wr_req.bready <= 1'b1;
    t = 0;
    do begin
      @(posedge fixed_clk);
      t++;
    end while (!wr_rsp.bvalid && t < TMO);
    if (!wr_rsp.bvalid) report_failure("no write response");
    wr_req.bready <= 1'b0;
    if (addr[4:2] == `UART_REG_LCR) lcr_sh = data[7:0];
    if (addr[4:2] == `UART_REG_DIV && lcr_sh[7]) div_sh = data[15:0];
  endtask

  task automatic bus_read(input logic [4:0] addr, output logic [31:0] data);
    int t;
    int delay;
    @(posedge fixed_clk);
    rd_req.araddr  <= addr;
    rd_req.arvalid <= 1'b1;
    t = 0;
    do begin
      @(posedge fixed_clk);
      t++;
    end while (!rd_rsp.arready && t < TMO);
    if (!rd_rsp.arready) report_failure("read address never accepted");
    data = rd_rsp.rdata;  // valid together with arready
    rd_req.arvalid <= 1'b0;
    delay = int'(lcg_next() >> 16) % 4;
    repeat (delay) @(posedge fixed_clk);
    rd_req.rready <= 1'b1;
    t = 0;
    do begin
      @(posedge fixed_clk);
      t++;
    end while (!rd_rsp.rvalid && t < TMO);
    if (!rd_rsp.rvalid) report_failure("no read data");
    rd_req.rready <= 1'b0;
  endtask

  task automatic send_serial(input logic [7:0] data, input logic bad_par);
    logic [11:0] bits;
    int          nbits;
    nbits = 10 + lcr_sh[1] + lcr_sh[0];
    if (lcr_sh[1]) bits = {2'b11, (^data) ^ lcr_sh[2] ^ bad_par, data, 1'b0};
    else bits = {3'b111, data, 1'b0};
    for (int i = 0; i < nbits; i++) begin
      @(posedge fixed_clk);
      uart_rx <= bits[i];
      repeat (div_sh - 1) @(posedge fixed_clk);  // one bit is div clocks
    end
    @(posedge fixed_clk);
  endtask

  task automatic expect_tx(input logic [7:0] exp);
    int         t;
    logic [7:0] got;
    t = 0;
    while (tx_seen.size() == 0 && t < TMO) begin
      @(posedge fixed_clk);
      t++;
    end
    if (tx_seen.size() == 0) begin
      report_failure("no byte transmitted on uart_tx_o");
    end else begin
      got = tx_seen.pop_front();
      if (got !== exp) report_mismatch("uart_tx_o byte", 32'(got), 32'(exp));
    end
  endtask

  task automatic wait_irq(input logic level);
    int t;
    t = 0;
    while (read_interrupt !== level && t < TMO) begin
      @(posedge fixed_clk);
      t++;
    end
    if (read_interrupt !== level)
      report_mismatch("read_interrupt_o", 32'(read_interrupt), 32'(level));
  endtask

  task automatic run_op(input int op, input logic [31:0] arg, input logic [31:0] value,
                        input int cnt);
    logic [31:0] got;
    for (int i = 0; i < cnt; i++) begin
      case (op)
        1: bus_write(arg[4:0], value + i);
        2: begin
          bus_read(arg[4:0], got);
          if (got !== value) report_mismatch("rdata", got, value);
        end
        3: send_serial(value[7:0], arg[0]);
        4: expect_tx(8'(value + i));
        5: wait_irq(value[0]);
        default: report_failure("unknown operation in testdata");
      endcase
    end
  endtask

  initial begin
    int          fd, n, cur, tnum, op, cnt;
    logic [31:0] arg, value;
    string       line;
    wr_req      = '0;
    rd_req      = '0;
    uart_rx     = 1'b1;
    axi_aresetn = 1'b0;
    lcr_sh      = '0;
    div_sh      = 16'(`UART_DIV_INIT);
    errors      = 0;
    test_err    = 0;
    tests       = 0;
    mon_left    = 0;
    mon_timer   = 0;
    repeat (4) @(posedge fixed_clk);
    axi_aresetn <= 1'b1;
    @(posedge fixed_clk);
    if (uart_tx !== 1'b1) report_mismatch("uart_tx_o", 32'(uart_tx), 32'd1);
    fd = $fopen("verif/axi_uart_testdata.txt", "r");
    if (fd == 0) report_failure("cannot open verif/axi_uart_testdata.txt");
    cur = 1;
    while (fd != 0 && !$feof(fd)) begin
      n = $fgets(line, fd);
      n = $sscanf(line, "%h %h %h %h %h", tnum, op, arg, value, cnt);
      if (n == 5) begin  // comment and blank lines parse short
        if (tnum != cur) begin
          finish_test(cur);
          cur = tnum;
        end
        run_op(op, arg, value, cnt);
      end
    end
    if (fd != 0) $fclose(fd);
    if (tx_seen.size() != 0) report_failure("unexpected bytes transmitted on uart_tx_o");
    finish_test(cur);
    $display("tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== verif/axi_uart_testdata.txt ====
# columns in hex: test op arg value count; count repeats the op with value+i
# op 1 write arg=addr, 2 read arg=addr value=expected, 3 serial in arg=1 bad parity
# op 4 expected tx byte, 5 expected interrupt level
1 2 14 00000060 1
1 5 00 00000000 1
1 2 18 00000000 1
2 1 0c 00000080 1
2 1 1c 00000008 1
2 1 0c 00000007 1
2 2 1c 00000008 1
2 1 00 000000a5 1
2 1 00 0000003c 1
2 4 00 000000a5 1
2 4 00 0000003c 1
3 3 00 0000005a 1
3 3 01 000000c3 1
3 3 00 00000081 1
3 2 14 00000061 1
3 2 00 0000005a 1
3 2 00 00000081 1
3 2 00 00000000 1
4 1 04 00000001 1
4 3 00 00000077 1
4 5 00 00000001 1
4 2 00 00000077 1
4 5 00 00000000 1
4 1 04 00000000 1
4 3 00 00000012 1
4 5 00 00000000 1
4 2 00 00000012 1
5 1 00 000000d0 a
5 4 00 000000d0 a
5 2 14 00000060 1
6 3 00 0000006b 1
6 1 0c 00000087 1
6 1 00 000000ee 1
6 2 00 00000000 1
6 1 0c 00000007 1
6 2 00 0000006b 1
6 2 14 00000060 1

// ==== sources.f ====
+incdir+hdl
hdl/axi_uart_pkg.sv
hdl/uart_fifo.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_axi_slave.sv
hdl/axi_uart_top.sv
verif/axi_uart_asserts.sv
verif/axi_uart_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps --top-module axi_uart_tb \
  -f sources.f -Mdir obj_dir -o axi_uart_sim
./obj_dir/axi_uart_sim | tee sim.log
if grep -qx "No errors" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
